// File: prefetch_fifo_macros.svh
// prefetch FIFO width macros
// address and data widths plus the derived RAM depth
// outside capacity is RAM depth plus the two output registers

`ifndef PREFETCH_FIFO_MACROS_SVH
`define PREFETCH_FIFO_MACROS_SVH

////////////////////////////////////////////////////////////
// sizing
////////////////////////////////////////////////////////////

`define PF_ADDR_W 4                        // ram address bits
`define PF_DATA_W 16                       // word width

// derived, keep in step with PF_ADDR_W
`define PF_DEPTH  (1 << `PF_ADDR_W)        // ram words

`endif

// File: prefetch_fifo_pkg.sv
// prefetch FIFO shared types
// address and data words, output register occupancy and the
// per-cycle operation of the output stage

`default_nettype none

`include "prefetch_fifo_macros.svh"

package prefetch_fifo_pkg;

  typedef logic [`PF_ADDR_W-1:0] pf_addr_t;   // ram address
  typedef logic [`PF_DATA_W-1:0] pf_data_t;   // one data word

  typedef enum logic [1:0] {
    SLOT_NONE = 2'd0,                         // output empty
    SLOT_ONE  = 2'd1,                         // head only
    SLOT_TWO  = 2'd2                          // head and tail
  } pf_slot_e;

  // decoded from {land, pop}
  typedef enum logic [1:0] {
    OP_HOLD  = 2'd0,                          // nothing moves
    OP_FILL  = 2'd1,                          // land only
    OP_DRAIN = 2'd2,                          // pop only
    OP_PASS  = 2'd3                           // land and pop
  } pf_stage_op_e;

endpackage

`default_nettype wire

// File: fifo_sdpram.sv
// simple dual-port RAM for the prefetch FIFO
// one write port, one read port with a registered output
// read register only loads while rd_clk_en is high, so the
// last word read stays on rd_data between fetches

`default_nettype none

`include "prefetch_fifo_macros.svh"

module fifo_sdpram (
  input  wire                           rd_clk,      // single clock
  input  wire                           wr_en,       // gated write strobe
  input  wire prefetch_fifo_pkg::pf_addr_t wr_addr,  // from ptr ctrl
  input  wire prefetch_fifo_pkg::pf_data_t wr_data,
  input  wire                           rd_clk_en,   // fetch strobe
  input  wire prefetch_fifo_pkg::pf_addr_t rd_addr,  // from ptr ctrl
  output prefetch_fifo_pkg::pf_data_t   rd_data      // valid cycle after fetch
);

  import prefetch_fifo_pkg::*;

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  pf_data_t mem [`PF_DEPTH];                        // word array

  always_ff @(posedge rd_clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;                      // write port
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // no collision possible, ptr ctrl never reads the slot being written
  always_ff @(posedge rd_clk)
  begin
    if (rd_clk_en)
    begin
      rd_data <= mem[rd_addr];                      // hold otherwise
    end
  end

endmodule

`default_nettype wire

// File: fifo_ptr_ctrl.sv
// pointer and flag controller for the prefetch FIFO RAM
// keeps write and read pointers plus a word count one bit wider
// than the address; full and empty are registered from the
// next count so they settle in the cycle after the update

`default_nettype none

`include "prefetch_fifo_macros.svh"

module fifo_ptr_ctrl (
  input  wire                            rd_clk,
  input  wire                            rd_rst,    // async, active high
  input  wire                            wr_push,   // write accepted
  input  wire                            fetch,     // ram read issued
  output prefetch_fifo_pkg::pf_addr_t    wr_addr,
  output prefetch_fifo_pkg::pf_addr_t    rd_addr,
  output logic                           full,
  output logic                           empty
);

  import prefetch_fifo_pkg::*;

  localparam logic [`PF_ADDR_W:0] cnt_full = (`PF_ADDR_W+1)'(`PF_DEPTH);  // all words used

  logic [`PF_ADDR_W:0] count;                       // words in ram
  logic [`PF_ADDR_W:0] count_nxt;

  ////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      wr_addr <= '0;
      rd_addr <= '0;
    end
    else
    begin
      if (wr_push)
        wr_addr <= wr_addr + 1'b1;                  // wraps at depth
      if (fetch)
        rd_addr <= rd_addr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // count and flags
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case ({wr_push, fetch})
      2'b10:   count_nxt = count + 1'b1;            // write only
      2'b01:   count_nxt = count - 1'b1;            // fetch only
      default: count_nxt = count;                   // both or neither
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      count <= '0;
      full  <= 1'b0;
      empty <= 1'b1;                                // nothing to fetch
    end
    else
    begin
      count <= count_nxt;
      full  <= (count_nxt == cnt_full);
      empty <= (count_nxt == '0);
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // top gates wr_en with wr_vld, so a push never meets full
  a_no_push_full: assert property (@(posedge rd_clk) disable iff (rd_rst)
    !(wr_push && full));

  // output stage only fetches while words remain
  a_no_fetch_empty: assert property (@(posedge rd_clk) disable iff (rd_rst)
    !(fetch && empty));

endmodule

`default_nettype wire

// File: prefetch_out_stage.sv
// prefetch output stage
// issues RAM reads ahead of the consumer, tracks the word sitting
// in the RAM read register and keeps up to two words in a small
// register FIFO so rd_data falls through without a read bubble
// head register drives rd_data directly

`default_nettype none

`include "prefetch_fifo_macros.svh"

module prefetch_out_stage (
  input  wire                            rd_clk,
  input  wire                            rd_rst,       // async, active high
  input  wire                            empty,        // ram holds no words
  input  wire prefetch_fifo_pkg::pf_data_t ram_rd_data, // ram read register
  input  wire                            rd_en,        // consumer take
  output logic                           fetch,        // ram read request
  output prefetch_fifo_pkg::pf_data_t    rd_data,      // head word
  output logic                           rd_vld        // head word present
);

  import prefetch_fifo_pkg::*;

  pf_slot_e     slot;                               // register fifo fill
  pf_slot_e     slot_nxt;
  pf_stage_op_e op;                                 // this cycle's move
  logic         in_flight;                          // word in ram read reg
  logic         land;                               // word enters stage
  logic         pop;                                // consumer takes head
  logic         room;                               // occupancy plus in-flight < 2
  pf_data_t     tail;                               // second word

  ////////////////////////////////////////////////////////////
  // fetch issue
  ////////////////////////////////////////////////////////////

  assign rd_vld = (slot != SLOT_NONE);
  assign pop    = rd_vld & rd_en;
  assign land   = in_flight;                        // one cycle after fetch
  assign room   = (slot == SLOT_NONE) || (slot == SLOT_ONE && !in_flight);
  assign fetch  = !empty && (room || pop);

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      in_flight <= 1'b0;
    else
      in_flight <= fetch;                           // ram data valid next cycle
  end

  ////////////////////////////////////////////////////////////
  // register fifo control
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case ({land, pop})
      2'b10:   op = OP_FILL;
      2'b01:   op = OP_DRAIN;
      2'b11:   op = OP_PASS;
      default: op = OP_HOLD;
    endcase
  end

  always_comb
  begin
    slot_nxt = slot;
    case (op)
      OP_FILL:  slot_nxt = (slot == SLOT_NONE) ? SLOT_ONE : SLOT_TWO;
      OP_DRAIN: slot_nxt = (slot == SLOT_TWO) ? SLOT_ONE : SLOT_NONE;
      default:  slot_nxt = slot;                    // pass keeps the count
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      slot <= SLOT_NONE;
    else
      slot <= slot_nxt;
  end

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rd_clk)
  begin
    case (op)
      OP_FILL:
      begin
        if (slot == SLOT_NONE)
          rd_data <= ram_rd_data;                   // straight to head
        else
          tail <= ram_rd_data;                      // queue behind head
      end
      OP_DRAIN:
      begin
        if (slot == SLOT_TWO)
          rd_data <= tail;                          // tail moves up
      end
      OP_PASS:
      begin
        if (slot == SLOT_TWO)
        begin
          rd_data <= tail;
          tail    <= ram_rd_data;
        end
        else
        begin
          rd_data <= ram_rd_data;                   // replace popped head
        end
      end
      default:
      begin
        tail <= tail;                               // hold both
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // fetch throttling keeps a landing word from overrunning a full stage
  a_no_overrun: assert property (@(posedge rd_clk) disable iff (rd_rst)
    !(land && slot == SLOT_TWO && !pop));

  // an unread head word stays put until the consumer takes it
  a_hold_head: assert property (@(posedge rd_clk) disable iff (rd_rst)
    (rd_vld && !rd_en) |=> (rd_vld && $stable(rd_data)));

endmodule

`default_nettype wire

// File: prefetch_fifo.sv
// prefetch FIFO top level
// single-clock FIFO with first-word-fall-through output
// pointer controller and dual-port RAM hold the bulk of the words,
// the output stage prefetches up to two of them ahead of rd_en
// wr_vld is not-full, rd_vld is data present

`default_nettype none

`include "prefetch_fifo_macros.svh"

module prefetch_fifo (
  input  wire                            rd_clk,
  input  wire                            rd_rst,    // async, active high
  input  wire prefetch_fifo_pkg::pf_data_t wr_data,
  input  wire                            wr_en,     // ignored while !wr_vld
  output logic                           wr_vld,    // room for a word
  output wire prefetch_fifo_pkg::pf_data_t rd_data,
  input  wire                            rd_en,     // take head word
  output wire                            rd_vld     // head word present
);

  import prefetch_fifo_pkg::*;

  pf_addr_t wr_addr;                                // ram write address
  pf_addr_t rd_addr;                                // ram read address
  pf_data_t ram_rd_data;                            // ram read register
  logic     wr_push;                                // accepted write
  logic     fetch;                                  // ram read strobe
  logic     full;
  logic     empty;

  ////////////////////////////////////////////////////////////
  // write gate
  ////////////////////////////////////////////////////////////

  assign wr_vld  = ~full;
  assign wr_push = wr_en & ~full;                   // drop writes when full

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  fifo_ptr_ctrl u_ptr_ctrl (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .wr_push (wr_push),
    .fetch   (fetch),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .full    (full),
    .empty   (empty)
  );

  fifo_sdpram u_sdpram (
    .rd_clk    (rd_clk),
    .wr_en     (wr_push),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk_en (fetch),                             // read reg loads on fetch
    .rd_addr   (rd_addr),
    .rd_data   (ram_rd_data)
  );

  prefetch_out_stage u_out_stage (
    .rd_clk      (rd_clk),
    .rd_rst      (rd_rst),
    .empty       (empty),
    .ram_rd_data (ram_rd_data),
    .rd_en       (rd_en),
    .fetch       (fetch),
    .rd_data     (rd_data),
    .rd_vld      (rd_vld)
  );

endmodule

`default_nettype wire

// File: prefetch_fifo_checker.sv
// prefetch FIFO scoreboard
// mirrors accepted writes in a reference queue, compares accepted
// reads with its head and watches hold, capacity and fall-through

`default_nettype none

`include "prefetch_fifo_macros.svh"

module prefetch_fifo_checker (
  input wire                              rd_clk,
  input wire                              rd_rst,
  input wire prefetch_fifo_pkg::pf_data_t wr_data,
  input wire                              wr_en,
  input wire                              wr_vld,
  input wire prefetch_fifo_pkg::pf_data_t rd_data,
  input wire                              rd_en,
  input wire                              rd_vld
);

  import prefetch_fifo_pkg::*;

  localparam int cap     = `PF_DEPTH + 2;           // ram plus two output regs
  localparam int max_lat = 3;                       // write to rd_vld, cycles

  pf_data_t ref_q [$];                              // words written, not yet read
  logic     hold_prev = 1'b0;                       // head was left unread
  int       late      = 0;                          // edges with data but no rd_vld
  int       errors    = 0;
  int       writes    = 0;
  int       reads     = 0;
  int       tests     = 0;
  int       err_mark  = 0;                          // counts at test start
  int       wr_mark   = 0;
  int       rd_mark   = 0;
  string    cur_name  = "none";

  task automatic value_error(input string what, input pf_data_t exp, input pf_data_t act);
    errors++;
    $display("ERR %s %s expected %h actual %h", cur_name, what, exp, act);
  endtask

  task automatic flag_fault(input string msg);
    errors++;
    $display("%s: %s at time %0t", cur_name, msg, $time);
  endtask

  ////////////////////////////////////////////////////////////
  // per-edge comparison
  ////////////////////////////////////////////////////////////

  always @(posedge rd_clk)
  begin : watch
    pf_data_t exp;
    if (rd_rst)
    begin
      ref_q.delete();
      late      = 0;
      hold_prev = 1'b0;
    end
    else
    begin
      if (hold_prev && !rd_vld)
        flag_fault("rd_vld dropped while the head word was unread");
      else if (hold_prev && ref_q.size() != 0 && rd_data !== ref_q[0])
        value_error("held head", ref_q[0], rd_data);  // oldest word stays on rd_data
      if (wr_vld && ref_q.size() >= cap)
        flag_fault("wr_vld high with the FIFO at capacity");
      if (ref_q.size() != 0 && !rd_vld)
        late++;                                     // still falling through
      else
        late = 0;
      if (late == max_lat + 1)
        flag_fault("rd_vld late after a write into the empty FIFO");
      if (rd_en && rd_vld)
      begin
        if (ref_q.size() == 0)
          flag_fault("word read that was never written");
        else
        begin
          exp = ref_q.pop_front();                  // oldest unread word
          if (rd_data !== exp)
            value_error("read", exp, rd_data);
        end
        reads++;
      end
      if (wr_en && wr_vld)
      begin
        ref_q.push_back(wr_data);
        writes++;
      end
      hold_prev = rd_vld && !rd_en;
    end
  end

  ////////////////////////////////////////////////////////////
  // calls from the testbench, made between edges
  ////////////////////////////////////////////////////////////

  function automatic int pending();
    return ref_q.size();
  endfunction

  task automatic begin_test(input string name);
    cur_name = name;
    err_mark = errors;
    wr_mark  = writes;
    rd_mark  = reads;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s: %0d written, %0d read, %0d errors", cur_name,
             writes - wr_mark, reads - rd_mark, errors - err_mark);
  endtask

  task automatic expect_idle();
    if (rd_vld !== 1'b0)
      flag_fault("rd_vld high with nothing queued");
    if (wr_vld !== 1'b1)
      flag_fault("wr_vld low with the FIFO empty");
    if (ref_q.size() != 0)
      flag_fault($sformatf("%0d words left unread", ref_q.size()));
  endtask

  task automatic confirm_full();
    if (wr_vld !== 1'b0)
      flag_fault("wr_vld still high after filling to capacity");
    if (ref_q.size() != cap)
      flag_fault($sformatf("%0d words accepted, capacity is %0d", ref_q.size(), cap));
    if (rd_vld !== 1'b1)
      flag_fault("rd_vld low with words queued");
  endtask

  task automatic report_totals();
    $display("tests %0d, words written %0d, words read %0d, errors %0d",
             tests, writes, reads, errors);
  endtask

endmodule

`default_nettype wire

// File: prefetch_fifo_tb.sv
// prefetch FIFO testbench
// table driven random traffic with LFSR enables, back-pressure
// and drain phases; the checker module does the comparing

`default_nettype none

`include "prefetch_fifo_macros.svh"

module prefetch_fifo_tb;

  import prefetch_fifo_pkg::*;

  localparam int n_tests = 5;

  logic        rd_clk;
  logic        rd_rst;
  logic        wr_en;
  logic        rd_en;
  logic        wr_vld;
  logic        rd_vld;
  pf_data_t    wr_data;
  pf_data_t    rd_data;
  logic [31:0] lfsr = 32'h5eca_85a5;                // stimulus seed

  ////////////////////////////////////////////////////////////
  // stimulus table, one row per test
  ////////////////////////////////////////////////////////////

  string test_name   [n_tests] = '{"fall_through", "random_mix", "burst_write",
                                   "back_pressure", "slow_read"};
  int    test_words  [n_tests] = '{12, 200, 100, `PF_DEPTH + 2, 60};  // accepted writes
  int    test_wr_pct [n_tests] = '{8, 50, 100, 100, 90};              // wr_en density
  int    test_rd_pct [n_tests] = '{100, 50, 70, 0, 25};               // rd_en density
  bit    test_full   [n_tests] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};     // ends at capacity
  bit    test_drain  [n_tests] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1};

  prefetch_fifo dut (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .wr_data (wr_data),
    .wr_en   (wr_en),
    .wr_vld  (wr_vld),
    .rd_data (rd_data),
    .rd_en   (rd_en),
    .rd_vld  (rd_vld)
  );

  prefetch_fifo_checker chk (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .wr_data (wr_data),
    .wr_en   (wr_en),
    .wr_vld  (wr_vld),
    .rd_data (rd_data),
    .rd_en   (rd_en),
    .rd_vld  (rd_vld)
  );

  initial
  begin
    rd_clk = 1'b0;
    forever #20 rd_clk = ~rd_clk;                   // period 40
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic pick(input int pct);
    logic [31:0] v;
    v = rand_bits(7);                               // 0..127
    return (int'(v) * 100) < (pct * 128);
  endfunction

  task automatic push_against_full();
    logic [31:0] r;
    repeat (4)
    begin
      @(posedge rd_clk);
      r = rand_bits(`PF_DATA_W);
      wr_data <= r[`PF_DATA_W-1:0];
      wr_en   <= 1'b1;                              // must be ignored
    end
    @(posedge rd_clk);
    wr_en <= 1'b0;
    @(negedge rd_clk);
    chk.confirm_full();
  endtask

  task automatic drain_fifo();
    @(posedge rd_clk);
    rd_en <= 1'b1;
    @(negedge rd_clk);
    while (chk.pending() != 0)
    begin
      @(negedge rd_clk);
    end
    chk.expect_idle();                              // rd_vld low, wr_vld high
    @(posedge rd_clk);
    rd_en <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int          accepted;
    logic [31:0] r;
    logic        wr_pick;
    logic        rd_pick;
    accepted = 0;
    chk.begin_test(test_name[t]);
    while (accepted < test_words[t])
    begin
      @(posedge rd_clk);
      if (wr_en && wr_vld)
        accepted++;                                 // taken at this edge
      r       = rand_bits(`PF_DATA_W);
      wr_pick = pick(test_wr_pct[t]);
      rd_pick = pick(test_rd_pct[t]);
      wr_data <= r[`PF_DATA_W-1:0];
      wr_en   <= wr_pick && (accepted < test_words[t]);
      rd_en   <= rd_pick;
    end
    if (test_full[t])
      push_against_full();
    if (test_drain[t])
      drain_fifo();
    @(negedge rd_clk);
    chk.end_test();
  endtask

  initial
  begin
    rd_rst  = 1'b1;
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    wr_data = '0;
    repeat (3) @(posedge rd_clk);
    rd_rst <= 1'b0;
    @(negedge rd_clk);
    chk.begin_test("reset_state");
    chk.expect_idle();
    chk.end_test();
    for (int t = 0; t < n_tests; t++)
      run_test(t);
    chk.report_totals();
    if (chk.errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // budget of 8 cycles per table word plus margin
  initial
  begin : watchdog
    int total;
    total = 0;
    for (int t = 0; t < n_tests; t++)
      total += test_words[t];
    repeat (total * 8 + 400) @(posedge rd_clk);
    $display("timeout: run did not finish within %0d cycles", total * 8 + 400);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
prefetch_fifo_pkg.sv
fifo_sdpram.sv
fifo_ptr_ctrl.sv
prefetch_out_stage.sv
prefetch_fifo.sv
prefetch_fifo_checker.sv
prefetch_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the prefetch FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
  --top-module prefetch_fifo_tb -o sim_prefetch_fifo

./obj_dir/sim_prefetch_fifo 2>&1 | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
